/* xtea_pkg.sv */
package xtea_pkg;

    // bus widths.
    localparam int xtea_block_w = 64;
    localparam int xtea_key_w   = 128;

    // round constant, derived from the golden ratio.
    localparam logic [31:0] xtea_delta = 32'h9E3779B9;

    // one cycle is two feistel rounds.
    localparam logic [5:0] xtea_cycles = 6'd32;

    // sum after all cycles, where decryption starts.
    localparam logic [31:0] xtea_dec_sum_init = xtea_delta * 32'd32;

    // v0 is the upper half of the block word.
    typedef union packed {
        logic [xtea_block_w-1:0] word;
        struct packed {
            logic [31:0] v0;
            logic [31:0] v1;
        } half;
    } xtea_block_u;

    typedef enum logic [2:0] {
        st_waiting      = 3'b000,
        st_encrypt      = 3'b001,
        st_encrypt_done = 3'b010,
        st_decrypt      = 3'b011,
        st_decrypt_done = 3'b100
    } xtea_state_e;

endpackage

/* xtea_core_if.sv */
`timescale 1ns/10ps

interface xtea_core_if import xtea_pkg::*; ();

    // request from the controller.
    logic                    start;
    logic [xtea_block_w-1:0] block;
    logic [xtea_key_w-1:0]   key;

    // completion from the core.
    logic                    ready;
    logic [xtea_block_w-1:0] result;

    modport ctrl (
        output start,
        output block,
        output key,
        input  ready,
        input  result
    );

    modport core (
        input  start,
        input  block,
        input  key,
        output ready,
        output result
    );

endinterface

/* xtea_enc.sv */
`timescale 1ns/10ps

module xtea_enc import xtea_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    xtea_core_if.core bus
);

    xtea_block_u           blk;
    logic [xtea_key_w-1:0] key_q;
    logic [31:0]           sum;
    logic [31:0]           sum_next;
    logic [31:0]           v0_next;
    logic [31:0]           v1_next;
    logic [5:0]            count;
    logic                  running;
    logic                  ready_q;

    function automatic logic [31:0] mix(input logic [31:0] v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    // k[0] sits in the top word of the key.
    function automatic logic [31:0] key_word(input logic [xtea_key_w-1:0] k,
                                             input logic [1:0] idx);
        return k[(3 - idx) * 32 +: 32];
    endfunction

    // both rounds of one cycle, v1 sees the new v0 and sum.
    assign sum_next = sum + xtea_delta;
    assign v0_next  = blk.half.v0 +
                      (mix(blk.half.v1) ^ (sum + key_word(key_q, sum[1:0])));
    assign v1_next  = blk.half.v1 +
                      (mix(v0_next) ^ (sum_next + key_word(key_q, sum_next[12:11])));

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (bus.start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                if (count == xtea_cycles) begin
                    running <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    count <= count + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.start) begin
            blk.word <= bus.block;
            key_q    <= bus.key;
            sum      <= '0;
        end else if (running && count != xtea_cycles) begin
            blk.word <= {v0_next, v1_next};
            sum      <= sum_next;
        end
    end

    assign bus.ready  = ready_q;
    assign bus.result = blk.word;

endmodule

/* xtea_dec.sv */
`timescale 1ns/10ps

module xtea_dec import xtea_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    xtea_core_if.core bus
);

    xtea_block_u           blk;
    logic [xtea_key_w-1:0] key_q;
    logic [31:0]           sum;
    logic [31:0]           sum_next;
    logic [31:0]           v0_next;
    logic [31:0]           v1_next;
    logic [5:0]            count;
    logic                  running;
    logic                  ready_q;

    function automatic logic [31:0] mix(input logic [31:0] v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    // same key word order as the encryption core.
    function automatic logic [31:0] key_word(input logic [xtea_key_w-1:0] k,
                                             input logic [1:0] idx);
        return k[(3 - idx) * 32 +: 32];
    endfunction

    // undo v1 first, then step sum back and undo v0.
    assign v1_next  = blk.half.v1 -
                      (mix(blk.half.v0) ^ (sum + key_word(key_q, sum[12:11])));
    assign sum_next = sum - xtea_delta;
    assign v0_next  = blk.half.v0 -
                      (mix(v1_next) ^ (sum_next + key_word(key_q, sum_next[1:0])));

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (bus.start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                if (count == xtea_cycles) begin
                    running <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    count <= count + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.start) begin
            blk.word <= bus.block;
            key_q    <= bus.key;
            sum      <= xtea_dec_sum_init;
        end else if (running && count != xtea_cycles) begin
            blk.word <= {v0_next, v1_next};
            sum      <= sum_next;
        end
    end

    assign bus.ready  = ready_q;
    assign bus.result = blk.word;

endmodule

/* xtea_ctrl.sv */
`timescale 1ns/10ps

module xtea_ctrl import xtea_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [xtea_block_w-1:0] data_in,
    input  logic [xtea_key_w-1:0]   key,
    input  logic                    start,
    input  logic                    enc_dec,
    output logic                    ready,
    output logic                    busy,
    output logic [xtea_block_w-1:0] data_out,
    xtea_core_if.ctrl               enc_bus,
    xtea_core_if.ctrl               dec_bus
);

    xtea_state_e             state;
    logic                    accept;
    logic                    enc_start;
    logic                    dec_start;
    logic [xtea_block_w-1:0] block_q;
    logic [xtea_key_w-1:0]   key_q;

    // start only counts while idle.
    assign accept = (state == st_waiting) && start;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_waiting;
        end else begin
            case (state)
                st_waiting: begin
                    if (start) begin
                        if (enc_dec) begin
                            state <= st_encrypt;
                        end else begin
                            state <= st_decrypt;
                        end
                    end
                end
                st_encrypt: begin
                    if (enc_bus.ready) begin
                        state <= st_encrypt_done;
                    end
                end
                st_decrypt: begin
                    if (dec_bus.ready) begin
                        state <= st_decrypt_done;
                    end
                end
                st_encrypt_done,
                st_decrypt_done: begin
                    state <= st_waiting;
                end
                default: begin
                    state <= st_waiting;
                end
            endcase
        end
    end

    // core strobes last one cycle since the state leaves waiting.
    always_ff @(posedge clock) begin
        if (reset) begin
            enc_start <= 1'b0;
            dec_start <= 1'b0;
            data_out  <= '0;
        end else begin
            enc_start <= accept && enc_dec;
            dec_start <= accept && !enc_dec;
            if (state == st_encrypt && enc_bus.ready) begin
                data_out <= enc_bus.result;
            end
            if (state == st_decrypt && dec_bus.ready) begin
                data_out <= dec_bus.result;
            end
        end
    end

    // request is held from acceptance until the core loads it.
    always_ff @(posedge clock) begin
        if (accept) begin
            block_q <= data_in;
            key_q   <= key;
        end
    end

    assign enc_bus.start = enc_start;
    assign enc_bus.block = block_q;
    assign enc_bus.key   = key_q;

    assign dec_bus.start = dec_start;
    assign dec_bus.block = block_q;
    assign dec_bus.key   = key_q;

    assign busy  = (state == st_encrypt) || (state == st_decrypt);
    assign ready = (state == st_encrypt_done) || (state == st_decrypt_done);

endmodule

/* xtea_top.sv */
`timescale 1ns/10ps

module xtea_top import xtea_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [xtea_block_w-1:0] data_in,
    input  logic [xtea_key_w-1:0]   key,
    input  logic                    start,
    input  logic                    enc_dec,
    output logic                    ready,
    output logic                    busy,
    output logic [xtea_block_w-1:0] data_out
);

    // one bus per cipher direction.
    xtea_core_if enc_bus ();
    xtea_core_if dec_bus ();

    xtea_ctrl i_ctrl (
        .clock    (clock),
        .reset    (reset),
        .data_in  (data_in),
        .key      (key),
        .start    (start),
        .enc_dec  (enc_dec),
        .ready    (ready),
        .busy     (busy),
        .data_out (data_out),
        .enc_bus  (enc_bus.ctrl),
        .dec_bus  (dec_bus.ctrl)
    );

    xtea_enc i_enc (
        .clock (clock),
        .reset (reset),
        .bus   (enc_bus.core)
    );

    xtea_dec i_dec (
        .clock (clock),
        .reset (reset),
        .bus   (dec_bus.core)
    );

endmodule

/* tb_xtea_assert.sv */
`timescale 1ns/10ps

module tb_xtea_assert import xtea_pkg::*; (
    input logic        clock,
    input logic        reset,
    input logic        enc_ready,
    input logic        dec_ready,
    input xtea_state_e state
);

    // a core may only finish while the controller waits for it.
    enc_ready_in_encrypt: assert property (
        @(posedge clock) disable iff (reset) enc_ready |-> state == st_encrypt
    ) else $error("encryption core finished outside the encrypt state");

    dec_ready_in_decrypt: assert property (
        @(posedge clock) disable iff (reset) dec_ready |-> state == st_decrypt
    ) else $error("decryption core finished outside the decrypt state");

endmodule

bind xtea_ctrl tb_xtea_assert i_assert (
    .clock     (clock),
    .reset     (reset),
    .enc_ready (enc_bus.ready),
    .dec_ready (dec_bus.ready),
    .state     (state)
);

/* tb_xtea.sv */
`timescale 1ns/10ps

module tb_xtea import xtea_pkg::*; ();

    localparam int clock_period    = 8;
    localparam int enc_count       = 6;
    localparam int dec_count       = 6;
    localparam int pair_count      = 4;
    localparam int intrude_count   = 2;
    localparam int n_trans         = enc_count + dec_count + 2 * pair_count + intrude_count;
    localparam int watchdog_cycles = n_trans * 40 + 200;
    localparam int latency         = 35;
    localparam int latency_limit   = 60;
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic          clock;
    logic          reset;
    logic [63:0]   data_in;
    logic [127:0]  key;
    logic          start;
    logic          enc_dec;
    logic          ready;
    logic          busy;
    logic [63:0]   data_out;

    logic [31:0]   lfsr_state = 32'hcfca;
    logic [63:0]   last_out;
    int            check_count;
    int            error_count;
    int            ready_count;
    logic [63:0]   exp_q[$];
    string         name_q[$];

    xtea_top i_dut (
        .clock    (clock),
        .reset    (reset),
        .data_in  (data_in),
        .key      (key),
        .start    (start),
        .enc_dec  (enc_dec),
        .ready    (ready),
        .busy     (busy),
        .data_out (data_out)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsr_taps;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit.
    task automatic draw_bits(input int n, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            value      = {value[126:0], lfsr_state[0]};
        end
    endtask

    // key word 0 is the top 32 bits.
    function automatic logic [63:0] xtea_ref_encrypt(input logic [63:0] plain,
                                                     input logic [127:0] key_val);
        xtea_block_u b;
        logic [31:0] k [0:3];
        logic [31:0] sum;
        b.word = plain;
        sum    = '0;
        for (int w = 0; w < 4; w++) begin
            k[w] = key_val[127 - 32 * w -: 32];
        end
        for (int i = 0; i < int'(xtea_cycles); i++) begin
            b.half.v0 = b.half.v0 + ((((b.half.v1 << 4) ^ (b.half.v1 >> 5)) + b.half.v1)
                                     ^ (sum + k[sum[1:0]]));
            sum = sum + xtea_delta;
            b.half.v1 = b.half.v1 + ((((b.half.v0 << 4) ^ (b.half.v0 >> 5)) + b.half.v0)
                                     ^ (sum + k[sum[12:11]]));
        end
        return b.word;
    endfunction

    function automatic logic [63:0] xtea_ref_decrypt(input logic [63:0] cipher,
                                                     input logic [127:0] key_val);
        xtea_block_u b;
        logic [31:0] k [0:3];
        logic [31:0] sum;
        b.word = cipher;
        sum    = xtea_dec_sum_init;
        for (int w = 0; w < 4; w++) begin
            k[w] = key_val[127 - 32 * w -: 32];
        end
        for (int i = 0; i < int'(xtea_cycles); i++) begin
            b.half.v1 = b.half.v1 - ((((b.half.v0 << 4) ^ (b.half.v0 >> 5)) + b.half.v0)
                                     ^ (sum + k[sum[12:11]]));
            sum = sum - xtea_delta;
            b.half.v0 = b.half.v0 - ((((b.half.v1 << 4) ^ (b.half.v1 >> 5)) + b.half.v1)
                                     ^ (sum + k[sum[1:0]]));
        end
        return b.word;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    // engine idle, outputs hold.
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clock);
            check_value("idle busy", 64'd0, {63'd0, busy});
            check_value("idle ready", 64'd0, {63'd0, ready});
            check_value("idle data_out", last_out, data_out);
        end
    endtask

    task automatic run_request(input string name, input logic mode,
                               input logic [63:0] block, input logic [127:0] key_val,
                               input logic [63:0] expected, input logic intrude,
                               input logic [63:0] other_block,
                               input logic [127:0] other_key);
        int   edges;
        logic done;
        exp_q.push_back(expected);
        name_q.push_back(name);
        @(posedge clock);
        #1;
        data_in = block;
        key     = key_val;
        enc_dec = mode;
        start   = 1'b1;
        // this edge samples start.
        @(posedge clock);
        #1;
        start   = 1'b0;
        data_in = ~block;
        edges   = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (ready) begin
                done = 1'b1;
                check_value({name, " latency"}, 64'(latency), 64'(edges));
                check_value({name, " busy at ready"}, 64'd0, {63'd0, busy});
            end else if (edges >= latency_limit) begin
                done = 1'b1;
                report_failure({name, ": ready never came after start"});
            end else begin
                check_value({name, " busy"}, 64'd1, {63'd0, busy});
                check_value({name, " held data_out"}, last_out, data_out);
                @(posedge clock);
                edges++;
                #1;
                if (intrude && edges == 10) begin
                    data_in = other_block;
                    key     = other_key;
                    start   = 1'b1;
                end else begin
                    start = 1'b0;
                end
            end
        end
        last_out = expected;
    endtask

    // compares data_out on every ready pulse.
    initial begin
        string       name;
        logic [63:0] expected;
        forever begin
            @(negedge clock);
            if (!reset && ready) begin
                ready_count++;
                if (exp_q.size() == 0) begin
                    report_failure("ready pulse with no request outstanding");
                end else begin
                    name     = name_q.pop_front();
                    expected = exp_q.pop_front();
                    check_value(name, expected, data_out);
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired before all transactions completed");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [127:0] raw;
        logic [63:0]  blk;
        logic [63:0]  cipher;
        logic [63:0]  other_blk;
        logic [127:0] k;
        logic [127:0] other_k;
        reset       = 1'b1;
        start       = 1'b0;
        enc_dec     = 1'b0;
        data_in     = '0;
        key         = '0;
        last_out    = '0;
        check_count = 0;
        error_count = 0;
        ready_count = 0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clock);
            check_value("reset busy", 64'd0, {63'd0, busy});
            check_value("reset ready", 64'd0, {63'd0, ready});
            check_value("reset data_out", 64'd0, data_out);
        end

        for (int i = 0; i < enc_count; i++) begin
            draw_bits(64, raw);
            blk = raw[63:0];
            draw_bits(128, k);
            run_request($sformatf("encrypt %0d", i), 1'b1, blk, k,
                        xtea_ref_encrypt(blk, k), 1'b0, '0, '0);
            draw_bits(2, raw);
            idle_cycles(int'(raw[1:0]));
        end

        for (int i = 0; i < dec_count; i++) begin
            draw_bits(64, raw);
            blk = raw[63:0];
            draw_bits(128, k);
            run_request($sformatf("decrypt %0d", i), 1'b0, blk, k,
                        xtea_ref_decrypt(blk, k), 1'b0, '0, '0);
            draw_bits(2, raw);
            idle_cycles(int'(raw[1:0]));
        end

        // decrypting the ciphertext must give the plaintext back.
        for (int i = 0; i < pair_count; i++) begin
            draw_bits(64, raw);
            blk = raw[63:0];
            draw_bits(128, k);
            cipher = xtea_ref_encrypt(blk, k);
            run_request($sformatf("round trip encrypt %0d", i), 1'b1, blk, k,
                        cipher, 1'b0, '0, '0);
            run_request($sformatf("round trip decrypt %0d", i), 1'b0, cipher, k,
                        blk, 1'b0, '0, '0);
        end

        for (int i = 0; i < intrude_count; i++) begin
            draw_bits(64, raw);
            blk = raw[63:0];
            draw_bits(128, k);
            draw_bits(64, raw);
            other_blk = raw[63:0];
            draw_bits(128, other_k);
            if (i % 2 == 0) begin
                run_request($sformatf("start while busy %0d", i), 1'b1, blk, k,
                            xtea_ref_encrypt(blk, k), 1'b1, other_blk, other_k);
            end else begin
                run_request($sformatf("start while busy %0d", i), 1'b0, blk, k,
                            xtea_ref_decrypt(blk, k), 1'b1, other_blk, other_k);
            end
            idle_cycles(3);
        end

        idle_cycles(4);
        check_value("ready pulse count", 64'(n_trans), 64'(ready_count));
        if (exp_q.size() != 0) begin
            report_failure("requests still waiting for a result at the end");
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
xtea_pkg.sv
xtea_core_if.sv
xtea_enc.sv
xtea_dec.sv
xtea_ctrl.sv
xtea_top.sv
tb_xtea_assert.sv
tb_xtea.sv

/* run.sh */
#!/bin/sh
# builds and runs the XTEA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_xtea \
    -f vlog.f -o sim_xtea > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_xtea > sim.log 2>&1

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
